// File: tb_tcb_mem_sub.sv
////////////////////////////////////////////////////////////
// tcb memory subsystem testbench
// seeded random traffic against a byte array model,
// in-order response checks, back-pressure and credits
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_tcb_mem_sub;

  import tcb_pkg::*;

  // dut ports
  logic     tcb;
  logic     rst_n;
  logic     req_vld;
  tcb_req_t req;
  logic     req_rdy;
  logic     rsp_vld;
  tcb_rsp_t rsp;
  logic     rsp_rdy;

  // reference memory and expected responses in request order
  logic [7:0] model_mem [tcb_mem_siz];
  tcb_rsp_t   exp_q [$];

  // error and test bookkeeping
  int errs;
  int errs_at_start;
  int pass_cnt;
  int fail_cnt;

  tcb_mem_sub u_tcb_mem_sub (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req     (req),
    .req_rdy (req_rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp),
    .rsp_rdy (rsp_rdy)
  );

  // 40 ns period
  always #20 tcb = ~tcb;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // executes one request on the model, returns its response
  function automatic tcb_rsp_t model_apply(input tcb_req_t r);
    tcb_rsp_t e;
    int       nb;
    int       a;
    e = '0;
    if (r.siz == 2'd3) begin
      // unsupported size, memory untouched
      e.sts.err = 1'b1;
    end else begin
      nb = 1 << r.siz;
      for (int b = 0; b < nb; b++) begin
        // wrap at the top of memory
        a = (int'(r.adr) + b) % tcb_mem_siz;
        if (r.wen) begin
          model_mem[a] = r.wdt[b];
        end else begin
          e.rdt[b] = model_mem[a];
        end
      end
    end
    return e;
  endfunction

  // random request, log size 0..2, some addresses near the top
  function automatic tcb_req_t rand_req();
    tcb_req_t r;
    r     = '0;
    r.siz = 2'($urandom_range(0, 2));
    r.wen = 1'($urandom_range(0, 1));
    if ($urandom_range(0, 3) == 0) begin
      r.adr = 8'(tcb_mem_siz - 4 + $urandom_range(0, 3));
    end else begin
      r.adr = 8'($urandom);
    end
    // data only in lanes below the size
    for (int b = 0; b < (1 << r.siz); b++) begin
      r.wdt[b] = 8'($urandom);
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // monitor, samples mid cycle ahead of the transfer edge
  ////////////////////////////////////////////////////////////

  always @(negedge tcb) begin
    if (rst_n && req_vld && req_rdy) begin
      exp_q.push_back(model_apply(req));
    end
    if (rst_n && rsp_vld && rsp_rdy) begin
      assert (exp_q.size() > 0) else begin
        $display("unexpected response at %0t with no request outstanding", $time);
        errs++;
      end
      if (exp_q.size() > 0) begin
        assert (rsp === exp_q[0]) else begin
          $display("error at %0t: expected rdt %h err %b, got rdt %h err %b",
                   $time, exp_q[0].rdt, exp_q[0].sts.err, rsp.rdt, rsp.sts.err);
          errs++;
        end
        void'(exp_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // driver tasks
  ////////////////////////////////////////////////////////////

  // ends the run on a handshake that never completes
  task automatic abort_run(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Test failed");
    $finish;
  endtask

  // offers one request, returns 2 ns after the transfer edge
  task automatic send_req(input tcb_req_t r);
    int n;
    n       = 0;
    req_vld = 1'b1;
    req     = r;
    @(negedge tcb);
    while (!req_rdy && n < 200) begin
      @(negedge tcb);
      n++;
    end
    if (!req_rdy) begin
      abort_run("request handshake never completed, req_rdy stayed low");
    end
    @(posedge tcb);
    #2;
  endtask

  // waits until every expected response came back
  task automatic drain_rsp();
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < 200) begin
      @(posedge tcb);
      #2;
      n++;
    end
    if (exp_q.size() > 0) begin
      abort_run("response handshake never completed, rsp_vld missing");
    end
  endtask

  task automatic start_test();
    errs_at_start = errs;
  endtask

  // one result line per test
  task automatic end_test(input string name);
    if (errs == errs_at_start) begin
      $display("test %s: pass", name);
      pass_cnt++;
    end else begin
      $display("test %s: fail, %0d errors", name, errs - errs_at_start);
      fail_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    tcb_req_t r;
    int       n_acc;
    int       cyc;
    int       stall;
    int       sent;
    logic     acc;
    logic     got;
    tcb       = 1'b0;
    rst_n     = 1'b0;
    req_vld   = 1'b0;
    req       = '0;
    rsp_rdy   = 1'b0;
    errs      = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    void'($urandom(32'h57cf70b5));
    repeat (4) @(posedge tcb);
    #2;
    rst_n = 1'b1;

    // 1. idle state after reset
    start_test();
    @(negedge tcb);
    assert (!rsp_vld && req_rdy) else begin
      $display("error at %0t: after reset rsp_vld %b req_rdy %b", $time, rsp_vld, req_rdy);
      errs++;
    end
    @(posedge tcb);
    #2;
    end_test("reset state");

    // 2. word writes to every aligned address, then read back
    start_test();
    rsp_rdy = 1'b1;
    for (int a = 0; a < tcb_mem_siz; a += tcb_ben) begin
      r     = '0;
      r.adr = 8'(a);
      r.wen = 1'b1;
      r.siz = 2'd2;
      r.wdt = $urandom;
      send_req(r);
    end
    for (int a = 0; a < tcb_mem_siz; a += tcb_ben) begin
      r     = '0;
      r.adr = 8'(a);
      r.siz = 2'd2;
      send_req(r);
    end
    req_vld = 1'b0;
    drain_rsp();
    end_test("fill and read back");

    // 3. random mixed sizes, addresses and directions
    start_test();
    for (int i = 0; i < 300; i++) begin
      send_req(rand_req());
    end
    req_vld = 1'b0;
    drain_rsp();
    end_test("random mixed traffic");

    // 4. log size 3 errors out, then word read shows no change
    start_test();
    for (int i = 0; i < 8; i++) begin
      r     = '0;
      r.adr = 8'($urandom);
      r.siz = 2'd3;
      r.wen = 1'b1;
      r.wdt = $urandom;
      send_req(r);
      r.wen = 1'b0;
      send_req(r);
      r.siz = 2'd2;
      send_req(r);
    end
    req_vld = 1'b0;
    drain_rsp();
    end_test("unsupported size");

    // 5. phase 1, responses held back until credits run out
    start_test();
    rsp_rdy = 1'b0;
    req     = rand_req();
    req_vld = 1'b1;
    n_acc   = 0;
    cyc     = 0;
    @(negedge tcb);
    while (req_rdy && cyc < 200) begin
      @(posedge tcb);
      #2;
      n_acc++;
      req = rand_req();
      @(negedge tcb);
      cyc++;
    end
    if (req_rdy) begin
      abort_run("req_rdy never dropped while responses were held back");
    end
    assert (n_acc <= 2 * tcb_fifo_dep + 1) else begin
      $display("error at %0t: %0d requests accepted under back-pressure", $time, n_acc);
      errs++;
    end
    // ready must stay low while nothing drains
    for (int i = 0; i < 8; i++) begin
      assert (!req_rdy) else begin
        $display("error at %0t: req_rdy high while responses held", $time);
        errs++;
      end
      @(negedge tcb);
    end

    // phase 2, random response ready, pending request counts as first
    @(posedge tcb);
    #2;
    sent  = 0;
    stall = 0;
    while ((sent < 30 || exp_q.size() != 0) && stall < 200) begin
      rsp_rdy = 1'($urandom_range(0, 1));
      @(negedge tcb);
      acc = req_vld && req_rdy;
      got = rsp_vld && rsp_rdy;
      @(posedge tcb);
      #2;
      if (acc) begin
        sent++;
        if (sent < 30) begin
          req = rand_req();
        end else begin
          req_vld = 1'b0;
        end
      end
      stall = (acc || got) ? 0 : stall + 1;
    end
    if (stall >= 200) begin
      abort_run("request or response handshake stalled after back-pressure release");
    end
    rsp_rdy = 1'b1;
    repeat (4) @(posedge tcb);
    #2;
    end_test("back-pressure and credits");

    $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tcb_fifo.sv
////////////////////////////////////////////////////////////
// tcb queue
// register based in-order circular buffer, payload type
// given as a type parameter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_fifo #(
  parameter type T = logic
)(
  input  logic tcb,
  input  logic rst_n,
  input  logic push,
  input  T     wdata,
  input  logic pop,
  output T     rdata,
  output logic empty,
  output logic full
);

  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////

  // entry array, no reset
  T buf_mem [tcb_fifo_dep];

  logic [$clog2(tcb_fifo_dep)-1:0] wr_ptr;
  logic [$clog2(tcb_fifo_dep)-1:0] rd_ptr;
  logic [tcb_cnt_w-1:0]            cnt;

  // qualified push and pop
  logic wr_en;
  logic rd_en;

  // push ignored while full, pop ignored while empty
  assign wr_en = push & ~full;
  assign rd_en = pop & ~empty;

  // status flags from occupancy
  assign empty = (cnt == '0);
  assign full  = (cnt == tcb_cnt_w'(tcb_fifo_dep));

  // head of queue
  assign rdata = buf_mem[rd_ptr];

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      // write pointer wraps at depth
      if (wr_en) begin
        wr_ptr <= (int'(wr_ptr) == tcb_fifo_dep - 1) ? '0 : wr_ptr + 1'b1;
      end
      // read pointer wraps at depth
      if (rd_en) begin
        rd_ptr <= (int'(rd_ptr) == tcb_fifo_dep - 1) ? '0 : rd_ptr + 1'b1;
      end
      // occupancy, unchanged on push with pop
      case ({wr_en, rd_en})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  // payload write
  always_ff @(posedge tcb) begin
    if (wr_en) begin
      buf_mem[wr_ptr] <= wdata;
    end
  end

endmodule

// File: tcb_mem_resp.sv
////////////////////////////////////////////////////////////
// tcb memory responder
// byte memory executing queued requests in order, one
// response pushed per popped request
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_mem_resp (
  input  logic              tcb,
  input  logic              rst_n,
  // request queue read side
  input  logic              empty,
  input  tcb_pkg::tcb_req_t head,
  output logic              pop,
  // credit return to issuer
  output logic              crd_ret,
  // response queue write side
  input  logic              rsp_full,
  output logic              rsp_push,
  output tcb_pkg::tcb_rsp_t rsp
);

  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  // byte memory, contents undefined after reset
  logic [8-1:0] mem [tcb_mem_siz];

  // size decode
  logic               err;
  logic [tcb_ben-1:0] lane;

  // per lane byte address
  logic [tcb_adr_w-1:0] lane_adr [tcb_ben];

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // request waiting and room for its response
  assign pop = ~empty & ~rsp_full;

  // one credit per popped request
  assign crd_ret = pop;

  // every request gets a response
  assign rsp_push = pop;

  ////////////////////////////////////////////////////////////
  // size and address decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    // log size 3 is not supported
    err = (head.siz == 2'd3);
    for (int b = 0; b < tcb_ben; b++) begin
      // lane active below 2**siz bytes
      lane[b] = !err && (b < (1 << head.siz));
      // wraps at the top of memory, address space equals memory size
      lane_adr[b] = head.adr + tcb_adr_w'(b);
    end
  end

  ////////////////////////////////////////////////////////////
  // read data and status
  ////////////////////////////////////////////////////////////

  always_comb begin
    // inactive lanes and writes return zero
    rsp         = '0;
    rsp.sts.err = err;
    if (!head.wen) begin
      for (int b = 0; b < tcb_ben; b++) begin
        if (lane[b]) begin
          rsp.rdt[b] = mem[lane_adr[b]];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // write access
  ////////////////////////////////////////////////////////////

  // same edge as pop and response push
  always_ff @(posedge tcb) begin
    if (pop && head.wen) begin
      for (int b = 0; b < tcb_ben; b++) begin
        // no lanes active on error
        if (lane[b]) begin
          mem[lane_adr[b]] <= head.wdt[b];
        end
      end
    end
  end

endmodule

// File: tcb_mem_sub.f
tcb_pkg.sv
tcb_fifo.sv
tcb_req_issue.sv
tcb_mem_resp.sv
tcb_mem_sub.sv
tb_tcb_mem_sub.sv

// File: tcb_mem_sub.sv
////////////////////////////////////////////////////////////
// tcb memory subsystem top
// issuer, request queue, memory responder, response queue
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_mem_sub (
  input  logic              tcb,
  input  logic              rst_n,
  // host request side
  input  logic              req_vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              req_rdy,
  // host response side
  output logic              rsp_vld,
  output tcb_pkg::tcb_rsp_t rsp,
  input  logic              rsp_rdy
);

  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  // issuer to request queue
  logic     req_push;
  tcb_req_t req_push_dat;

  // request queue to responder
  logic     req_pop;
  logic     req_empty;
  tcb_req_t req_head;

  // credit loop
  logic crd_ret;

  // responder to response queue
  logic     rsp_push;
  tcb_rsp_t rsp_push_dat;
  logic     rsp_full;
  logic     rsp_empty;

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////

  tcb_req_issue u_req_issue (
    .tcb      (tcb),
    .rst_n    (rst_n),
    .req_vld  (req_vld),
    .req      (req),
    .req_rdy  (req_rdy),
    .crd_ret  (crd_ret),
    .push     (req_push),
    .push_req (req_push_dat)
  );

  // full never seen, credits bound the occupancy
  tcb_fifo #(
    .T (tcb_req_t)
  ) u_req_fifo (
    .tcb   (tcb),
    .rst_n (rst_n),
    .push  (req_push),
    .wdata (req_push_dat),
    .pop   (req_pop),
    .rdata (req_head),
    .empty (req_empty),
    .full  ()
  );

  ////////////////////////////////////////////////////////////
  // memory and response path
  ////////////////////////////////////////////////////////////

  tcb_mem_resp u_mem_resp (
    .tcb      (tcb),
    .rst_n    (rst_n),
    .empty    (req_empty),
    .head     (req_head),
    .pop      (req_pop),
    .crd_ret  (crd_ret),
    .rsp_full (rsp_full),
    .rsp_push (rsp_push),
    .rsp      (rsp_push_dat)
  );

  tcb_fifo #(
    .T (tcb_rsp_t)
  ) u_rsp_fifo (
    .tcb   (tcb),
    .rst_n (rst_n),
    .push  (rsp_push),
    .wdata (rsp_push_dat),
    .pop   (rsp_vld & rsp_rdy),
    .rdata (rsp),
    .empty (rsp_empty),
    .full  (rsp_full)
  );

  // response valid while the queue holds an entry
  assign rsp_vld = ~rsp_empty;

endmodule

// File: tcb_pkg.sv
////////////////////////////////////////////////////////////
// tcb memory subsystem package
// bus sizes, request and response structs, status encoding
////////////////////////////////////////////////////////////

package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  // byte address width
  localparam int unsigned tcb_adr_w = 8;

  // data bytes per transfer
  localparam int unsigned tcb_ben = 4;

  // memory size in bytes, full address space
  localparam int unsigned tcb_mem_siz = 2**tcb_adr_w;

  // queue depth, also the credit count after reset
  localparam int unsigned tcb_fifo_dep = 4;

  // credit counter and queue occupancy width
  // must hold values 0 to tcb_fifo_dep inclusive
  localparam int unsigned tcb_cnt_w = 3;

  ////////////////////////////////////////////////////////////
  // bus structs
  ////////////////////////////////////////////////////////////

  // response status
  typedef struct packed {
    // unsupported transfer size
    logic err;
  } tcb_sts_t;

  // request
  typedef struct packed {
    logic [tcb_adr_w-1:0]      adr;
    logic                      wen;
    // log2 of transfer size in bytes
    logic [1:0]                siz;
    logic [tcb_ben-1:0][8-1:0] wdt;
  } tcb_req_t;

  // response
  typedef struct packed {
    logic [tcb_ben-1:0][8-1:0] rdt;
    tcb_sts_t                  sts;
  } tcb_rsp_t;

endpackage

// File: tcb_req_issue.sv
////////////////////////////////////////////////////////////
// tcb request issuer
// admits host requests against a credit counter and
// forwards them into the request queue
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_req_issue (
  input  logic              tcb,
  input  logic              rst_n,
  // host request side
  input  logic              req_vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              req_rdy,
  // credit return from responder
  input  logic              crd_ret,
  // request queue push side
  output logic              push,
  output tcb_pkg::tcb_req_t push_req
);

  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////
  // credit counter
  ////////////////////////////////////////////////////////////

  // free slots in the request queue
  logic [tcb_cnt_w-1:0] crd_cnt;

  // host transfer
  logic trn;

  // ready only on credit, independent of valid
  assign req_rdy = (crd_cnt != '0);

  assign trn = req_vld & req_rdy;

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      // queue starts empty, all slots free
      crd_cnt <= tcb_cnt_w'(tcb_fifo_dep);
    end else begin
      case ({trn, crd_ret})
        // accepted, slot taken
        2'b10:   crd_cnt <= crd_cnt - 1'b1;
        // responder popped, slot freed
        2'b01:   crd_cnt <= crd_cnt + 1'b1;
        // both or neither
        default: crd_cnt <= crd_cnt;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // queue push
  ////////////////////////////////////////////////////////////

  // same cycle as the host transfer
  assign push     = trn;
  assign push_req = req;

endmodule
